/* src/recog_fmt_pkg.sv */
`default_nettype none

package recog_fmt_pkg;

    localparam int DAT_W    = 22;
    localparam int PAR_W    = 16;
    localparam int FP_SHIFT = 14; // fraction bits
    localparam int ACC_W    = DAT_W + PAR_W + 4; // headroom for long sums

    // activations and logits
    typedef logic signed [DAT_W-1:0] data_t;

    // weights and biases
    typedef logic signed [PAR_W-1:0] par_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    // a set pixel reads as 1.0
    localparam data_t FP_ONE = data_t'(2 ** FP_SHIFT);

endpackage

`default_nettype wire

/* src/recog_ctrl_pkg.sv */
`default_nettype none

package recog_ctrl_pkg;

    import recog_fmt_pkg::*;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_READ,  // canvas fetch
        PH_DENSE, // products and pipeline drain
        PH_DONE
    } phase_e;

    // one accumulation step
    typedef struct packed {
        logic       valid;
        logic       first; // restart the sum
        logic       last;  // close the class
        logic [7:0] cls;
    } mac_ctrl_t;

    // one parameter write from the load port
    typedef struct packed {
        logic        we;
        logic        is_bias;
        logic [7:0]  cls;
        logic [15:0] pix;
        par_t        value;
    } param_load_t;

endpackage

`default_nettype wire

/* src/layer_sequencer.sv */
`default_nettype none

module layer_sequencer
    import recog_ctrl_pkg::*;
#(
    parameter int CANVAS_W    = 32,
    parameter int NUM_CLASSES = 10
) (
    input  wire                                     clk,
    input  wire                                     rst,
    input  wire                                     start_i,
    output logic [$clog2(CANVAS_W*CANVAS_W)-1:0]    read_addr_o,
    output logic                                    read_enable_o,
    output logic [$clog2(CANVAS_W*CANVAS_W)-1:0]    pix_idx_o,
    output mac_ctrl_t                               mac_ctrl_o,
    output logic                                    pending_o,
    output logic                                    result_valid_o
);

    localparam int NPIX  = CANVAS_W * CANVAS_W;
    localparam int AW    = $clog2(NPIX);
    // params read, then mac, then argmax after the last issue
    localparam int DRAIN = 2;

    localparam logic [AW-1:0] LAST_PIX   = AW'(NPIX - 1);
    localparam logic [AW-1:0] LAST_DRAIN = AW'(DRAIN - 1);
    localparam logic [7:0]    LAST_CLS   = 8'(NUM_CLASSES - 1);

    phase_e         phase;
    logic [AW-1:0]  pix_cnt;
    logic [7:0]     cls_cnt;
    logic           issuing;
    logic           pix_wrap;

    // class counter past the last class means draining
    assign issuing  = (phase == PH_DENSE) && (cls_cnt <= LAST_CLS);
    assign pix_wrap = (pix_cnt == LAST_PIX);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= PH_IDLE;
            pix_cnt <= '0;
            cls_cnt <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    pix_cnt <= '0;
                    cls_cnt <= '0;
                    if (start_i) begin
                        phase <= PH_READ;
                    end
                end
                PH_READ: begin
                    pix_cnt <= pix_wrap ? '0 : pix_cnt + 1'b1;
                    if (pix_wrap) begin
                        phase <= PH_DENSE;
                    end
                end
                PH_DENSE: begin
                    if (issuing) begin
                        pix_cnt <= pix_wrap ? '0 : pix_cnt + 1'b1;
                        if (pix_wrap) begin
                            cls_cnt <= cls_cnt + 1'b1;
                        end
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1; // reused as drain count
                        if (pix_cnt == LAST_DRAIN) begin
                            phase <= PH_DONE;
                        end
                    end
                end
                default: begin
                    phase   <= PH_IDLE;
                    pix_cnt <= '0;
                    cls_cnt <= '0;
                end
            endcase
        end
    end

    assign read_addr_o   = pix_cnt;
    assign read_enable_o = (phase == PH_READ);
    assign pix_idx_o     = pix_cnt;

    always_comb begin
        mac_ctrl_o.valid = issuing;
        mac_ctrl_o.first = issuing && (pix_cnt == '0);
        mac_ctrl_o.last  = issuing && pix_wrap;
        mac_ctrl_o.cls   = cls_cnt;
    end

    assign pending_o      = (phase == PH_READ) || (phase == PH_DENSE);
    assign result_valid_o = (phase == PH_DONE); // argmax lands on this cycle

endmodule

`default_nettype wire

/* src/canvas_buffer.sv */
`default_nettype none

module canvas_buffer
    import recog_fmt_pkg::*;
#(
    parameter int CANVAS_W = 32
) (
    input  wire                                     clk,
    input  wire                                     wr_en_i,
    input  wire  [$clog2(CANVAS_W*CANVAS_W)-1:0]    wr_addr_i,
    input  wire                                     wr_bit_i,
    input  wire  [$clog2(CANVAS_W*CANVAS_W)-1:0]    rd_idx_i,
    output data_t                                   pix_o
);

    localparam int NPIX = CANVAS_W * CANVAS_W;

    logic mem [NPIX];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_bit_i;
        end
    end

    // convert to fixed point on the way out
    always_ff @(posedge clk) begin
        pix_o <= mem[rd_idx_i] ? FP_ONE : '0;
    end

endmodule

`default_nettype wire

/* src/dense_params.sv */
`default_nettype none

module dense_params
    import recog_fmt_pkg::*;
    import recog_ctrl_pkg::*;
#(
    parameter int CANVAS_W    = 32,
    parameter int NUM_CLASSES = 10
) (
    input  wire                                     clk,
    input  param_load_t                             param_i,
    input  mac_ctrl_t                               mac_ctrl_i,
    input  wire  [$clog2(CANVAS_W*CANVAS_W)-1:0]    pix_idx_i,
    output par_t                                    weight_o,
    output par_t                                    bias_o,
    output mac_ctrl_t                               mac_ctrl_o
);

    localparam int NPIX = CANVAS_W * CANVAS_W;
    localparam int WA   = $clog2(NUM_CLASSES * NPIX);
    localparam int CW   = $clog2(NUM_CLASSES);

    par_t w_mem [NUM_CLASSES * NPIX]; // class-major
    par_t b_mem [NUM_CLASSES];

    logic [WA-1:0]  wr_addr;
    logic [WA-1:0]  rd_addr;
    logic           in_range;

    assign wr_addr  = WA'(int'(param_i.cls) * NPIX + int'(param_i.pix));
    assign rd_addr  = WA'(int'(mac_ctrl_i.cls) * NPIX + int'(pix_idx_i));
    assign in_range = (int'(param_i.cls) < NUM_CLASSES) && (int'(param_i.pix) < NPIX);

    // load port, used only while idle
    always_ff @(posedge clk) begin
        if (param_i.we && in_range) begin
            if (param_i.is_bias) begin
                b_mem[param_i.cls[CW-1:0]] <= param_i.value;
            end else begin
                w_mem[wr_addr] <= param_i.value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mac_ctrl_i.valid) begin
            weight_o <= w_mem[rd_addr];
            bias_o   <= b_mem[mac_ctrl_i.cls[CW-1:0]];
        end
        mac_ctrl_o <= mac_ctrl_i; // stays beside the pixel read
    end

endmodule

`default_nettype wire

/* src/dense_mac.sv */
`default_nettype none

module dense_mac
    import recog_fmt_pkg::*;
    import recog_ctrl_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  data_t       pix_i,
    input  par_t        weight_i,
    input  par_t        bias_i,
    input  mac_ctrl_t   mac_ctrl_i,
    output data_t       logit_o,
    output logic        logit_valid_o,
    output logic [7:0]  logit_cls_o
);

    acc_t   acc;
    acc_t   prod;
    acc_t   sum;
    acc_t   scaled;
    data_t  logit_next;

    assign prod = acc_t'(pix_i) * acc_t'(weight_i);

    // first product of a class starts from zero
    assign sum = (mac_ctrl_i.first ? acc_t'(0) : acc) + prod;

    assign scaled     = sum >>> FP_SHIFT;
    assign logit_next = data_t'(scaled) + data_t'(bias_i); // bias is unscaled

    always_ff @(posedge clk) begin
        if (mac_ctrl_i.valid) begin
            acc <= sum;
        end
        if (mac_ctrl_i.valid && mac_ctrl_i.last) begin
            logit_o     <= logit_next;
            logit_cls_o <= mac_ctrl_i.cls;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            logit_valid_o <= 1'b0;
        end else begin
            logit_valid_o <= mac_ctrl_i.valid && mac_ctrl_i.last;
        end
    end

endmodule

`default_nettype wire

/* src/argmax_tracker.sv */
`default_nettype none

module argmax_tracker
    import recog_fmt_pkg::*;
#(
    parameter int NUM_CLASSES = 10
) (
    input  wire         clk,
    input  wire         rst,
    input  data_t       logit_i,
    input  wire         logit_valid_i,
    input  wire  [7:0]  logit_cls_i,
    output logic [7:0]  result_o
);

    localparam logic [7:0] LAST_CLS = 8'(NUM_CLASSES - 1);

    data_t          max_val;
    logic [7:0]     max_idx;
    logic           take;

    // strict compare keeps the first maximum
    assign take = (logit_cls_i == 8'd0) || (logit_i > max_val);

    always_ff @(posedge clk) begin
        if (rst) begin
            max_val  <= '0;
            max_idx  <= '0;
            result_o <= '0;
        end else if (logit_valid_i) begin
            if (take) begin
                max_val <= logit_i;
                max_idx <= logit_cls_i;
            end
            if (logit_cls_i == LAST_CLS) begin
                result_o <= take ? logit_cls_i : max_idx;
            end
        end
    end

endmodule

`default_nettype wire

/* src/recognizer_top.sv */
`default_nettype none

module recognizer_top
    import recog_fmt_pkg::*;
    import recog_ctrl_pkg::*;
#(
    parameter int CANVAS_W    = 32,
    parameter int NUM_CLASSES = 10
) (
    input  wire                                     clk,
    input  wire                                     rst,
    input  wire                                     start_i,
    input  wire                                     read_data_i,
    output logic [$clog2(CANVAS_W*CANVAS_W)-1:0]    read_addr_o,
    output logic                                    read_enable_o,
    output logic                                    pending_o,
    output logic                                    result_valid_o,
    output logic [7:0]                              result_o,
    input  param_load_t                             param_i
);

    localparam int AW = $clog2(CANVAS_W * CANVAS_W);

    logic [AW-1:0]  pix_idx;
    mac_ctrl_t      seq_ctrl;
    mac_ctrl_t      mac_ctrl;   // aligned with pixel and weight
    data_t          pix;
    par_t           weight;
    par_t           bias;
    data_t          logit;
    logic           logit_valid;
    logic [7:0]     logit_cls;

    layer_sequencer #(
        .CANVAS_W    (CANVAS_W),
        .NUM_CLASSES (NUM_CLASSES)
    ) seq_i (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_i),
        .read_addr_o    (read_addr_o),
        .read_enable_o  (read_enable_o),
        .pix_idx_o      (pix_idx),
        .mac_ctrl_o     (seq_ctrl),
        .pending_o      (pending_o),
        .result_valid_o (result_valid_o)
    );

    // canvas is written straight from the read port
    canvas_buffer #(
        .CANVAS_W (CANVAS_W)
    ) canvas_i (
        .clk       (clk),
        .wr_en_i   (read_enable_o),
        .wr_addr_i (read_addr_o),
        .wr_bit_i  (read_data_i),
        .rd_idx_i  (pix_idx),
        .pix_o     (pix)
    );

    dense_params #(
        .CANVAS_W    (CANVAS_W),
        .NUM_CLASSES (NUM_CLASSES)
    ) params_i (
        .clk        (clk),
        .param_i    (param_i),
        .mac_ctrl_i (seq_ctrl),
        .pix_idx_i  (pix_idx),
        .weight_o   (weight),
        .bias_o     (bias),
        .mac_ctrl_o (mac_ctrl)
    );

    dense_mac mac_i (
        .clk           (clk),
        .rst           (rst),
        .pix_i         (pix),
        .weight_i      (weight),
        .bias_i        (bias),
        .mac_ctrl_i    (mac_ctrl),
        .logit_o       (logit),
        .logit_valid_o (logit_valid),
        .logit_cls_o   (logit_cls)
    );

    argmax_tracker #(
        .NUM_CLASSES (NUM_CLASSES)
    ) argmax_i (
        .clk           (clk),
        .rst           (rst),
        .logit_i       (logit),
        .logit_valid_i (logit_valid),
        .logit_cls_i   (logit_cls),
        .result_o      (result_o)
    );

endmodule

`default_nettype wire

/* test/tb_recognizer.sv */
`default_nettype none

module tb_recognizer
    import recog_fmt_pkg::*;
    import recog_ctrl_pkg::*;
();

    localparam int CANVAS_W    = 32;
    localparam int NUM_CLASSES = 10;
    localparam int NPIX        = CANVAS_W * CANVAS_W;
    localparam int AW          = $clog2(NPIX);
    localparam int RUN_LIMIT   = NPIX * (NUM_CLASSES + 1) + 100;
    localparam int DRV         = 1; // input delay after the rising edge

    logic           clk;
    logic           rst;
    logic           start_i;
    logic           read_data_i;
    logic [AW-1:0]  read_addr_o;
    logic           read_enable_o;
    logic           pending_o;
    logic           result_valid_o;
    logic [7:0]     result_o;
    param_load_t    param_i;

    bit             canvas [NPIX];
    int             weights [NUM_CLASSES][NPIX];
    int             biases [NUM_CLASSES];
    logic [31:0]    rng_state = 32'd86;

    int             errors = 0;
    int             checks = 0;
    int             results_seen = 0;
    int             exp_result = 0;
    int             exp_addr = 0;
    int             held_result = 0; // reset value of result_o
    bit             in_run = 1'b0;
    bit             prev_enable = 1'b0;
    bit             timed_out = 1'b0;

    recognizer_top #(
        .CANVAS_W    (CANVAS_W),
        .NUM_CLASSES (NUM_CLASSES)
    ) dut_i (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_i),
        .read_data_i    (read_data_i),
        .read_addr_o    (read_addr_o),
        .read_enable_o  (read_enable_o),
        .pending_o      (pending_o),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .param_i        (param_i)
    );

    assign read_data_i = canvas[read_addr_o]; // canvas model answers in the same cycle

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // first maximum over bias plus weights of set pixels
    function automatic int expected_class();
        int c;
        int p;
        int logit;
        int best;
        int best_val;
        best = 0;
        best_val = 0;
        for (c = 0; c < NUM_CLASSES; c++) begin
            logit = biases[c];
            for (p = 0; p < NPIX; p++) begin
                if (canvas[p]) begin
                    logit += weights[c][p];
                end
            end
            if (c == 0 || logit > best_val) begin
                best = c;
                best_val = logit;
            end
        end
        return best;
    endfunction

    task automatic compare_value(input string name, input int got, input int want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("error at time %0t: %s = %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic confirm(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("failure at time %0t: %s", $time, what);
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d checks, %0d errors, %0d results", checks, errors, results_seen);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic flag_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout at time %0t: %s", $time, what);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRV;
    endtask

    task automatic pulse_start();
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
    endtask

    task automatic write_param(input bit is_bias, input int cls, input int pix, input int value);
        param_i.we      = 1'b1;
        param_i.is_bias = is_bias;
        param_i.cls     = 8'(cls);
        param_i.pix     = 16'(pix);
        param_i.value   = par_t'(value);
        if (is_bias) begin
            biases[cls] = value;
        end else begin
            weights[cls][pix] = value;
        end
        next_cycle();
    endtask

    task automatic load_weights(input bit random_fill);
        int c;
        int p;
        for (c = 0; c < NUM_CLASSES; c++) begin
            for (p = 0; p < NPIX; p++) begin
                write_param(1'b0, c, p, random_fill ? int'(rand32() % 32'd2049) - 1024 : 0);
            end
        end
        param_i.we = 1'b0;
    endtask

    task automatic set_biases(input int lo, input int span);
        int c;
        for (c = 0; c < NUM_CLASSES; c++) begin
            write_param(1'b1, c, 0, lo + int'(rand32() % 32'(span)));
        end
        param_i.we = 1'b0;
    endtask

    task automatic draw_canvas(input int per_256);
        int p;
        for (p = 0; p < NPIX; p++) begin
            canvas[p] = int'(rand32() & 32'hff) < per_256;
        end
    endtask

    // one start and optional extra starts while busy, then wait for the result
    task automatic run_and_check(input bit poke_start);
        int n;
        int cnt;
        n = results_seen;
        exp_result = expected_class();
        pulse_start();
        if (poke_start) begin
            cnt = 0;
            while (!read_enable_o && cnt < 10) begin
                next_cycle();
                cnt++;
            end
            if (!read_enable_o) begin
                flag_timeout("read_enable_o did not rise after start");
                return;
            end
            pulse_start(); // during the read
            cnt = 0;
            while (read_enable_o && cnt < NPIX + 10) begin
                next_cycle();
                cnt++;
            end
            if (read_enable_o) begin
                flag_timeout("canvas read did not end");
                return;
            end
            pulse_start(); // during the dense phase
        end
        cnt = 0;
        while (results_seen == n && cnt < RUN_LIMIT) begin
            next_cycle();
            cnt++;
        end
        if (results_seen == n) begin
            flag_timeout("no result_valid_o pulse");
        end
    endtask

    task automatic run_scenarios();
        int run;

        // empty canvas so the biases decide
        draw_canvas(0);
        load_weights(1'b0);
        set_biases(-8000, 16001);
        run_and_check(1'b0);
        if (timed_out) begin
            return;
        end

        for (run = 0; run < 4; run++) begin
            draw_canvas(30 + run * 60);
            load_weights(1'b1);
            set_biases(-8000, 16001);
            run_and_check(run == 3);
            if (timed_out) begin
                return;
            end
        end

        // tie on classes 3, 5 and 8
        draw_canvas(128);
        load_weights(1'b0);
        set_biases(-2000, 2400);
        write_param(1'b1, 3, 0, 500);
        write_param(1'b1, 5, 0, 500);
        write_param(1'b1, 8, 0, 500);
        param_i.we = 1'b0;
        run_and_check(1'b0);
        if (timed_out) begin
            return;
        end

        set_biases(77, 1); // all classes equal
        run_and_check(1'b0);
    endtask

    // result_valid_o is a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) result_valid_o |=> !result_valid_o)
        else begin
            errors++;
            $display("failure at time %0t: result_valid_o high for more than one cycle", $time);
        end

    // output checks at mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (read_enable_o) begin
                in_run = 1'b1;
                confirm(exp_addr < NPIX, "read_enable_o high after the whole canvas was read");
                compare_value("read_addr_o", int'(read_addr_o), exp_addr);
                exp_addr++;
            end else if (prev_enable) begin
                confirm(exp_addr == NPIX, "canvas read stopped before the last pixel");
            end
            if (result_valid_o) begin
                confirm(in_run && exp_addr == NPIX, "result_valid_o without a full canvas read");
                compare_value("pending_o", int'(pending_o), 0);
                compare_value("result_o", int'(result_o), exp_result);
                held_result = int'(result_o);
                results_seen++;
                exp_addr = 0;
                in_run = 1'b0;
            end else begin
                compare_value("result_o", int'(result_o), held_result);
                compare_value("pending_o", int'(pending_o), in_run ? 1 : 0);
            end
            prev_enable = read_enable_o;
        end
    end

    initial begin
        rst     = 1'b1;
        start_i = 1'b0;
        param_i = '0;
        repeat (2) @(posedge clk);
        #DRV rst = 1'b0;
        @(negedge clk);
        compare_value("read_enable_o", int'(read_enable_o), 0);
        compare_value("pending_o", int'(pending_o), 0);
        compare_value("result_valid_o", int'(result_valid_o), 0);
        compare_value("result_o", int'(result_o), 0);
        next_cycle();
        run_scenarios();
        finish_run();
    end

endmodule

`default_nettype wire

/* project.f */
src/recog_fmt_pkg.sv
src/recog_ctrl_pkg.sv
src/layer_sequencer.sv
src/canvas_buffer.sv
src/dense_params.sv
src/dense_mac.sv
src/argmax_tracker.sv
src/recognizer_top.sv
test/tb_recognizer.sv

/* Makefile */
TOP = tb_recognizer

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
